// File: source/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// ---------------------------------------------------------------------------
// Datapath
// ---------------------------------------------------------------------------

`define BE_XLEN 32

// ---------------------------------------------------------------------------
// Register files and queues
// ---------------------------------------------------------------------------

// Register 0 is hardwired to zero
`define BE_ARCH_REGS 8
`define BE_PHYS_REGS 16

// Reorder buffer and integer issue queue
`define BE_ROB_DEPTH 8
`define BE_IQ_DEPTH 4

`endif

// File: source/BackendPkg.sv
`default_nettype none
`include "backend_defs.svh"

package BackendPkg;

    // ------------------------------------------------------------------------
    // Operations and indices
    // ------------------------------------------------------------------------

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluAddi
    } AluOp;

    typedef logic [$clog2(`BE_ARCH_REGS)-1:0] ArchIdx;
    typedef logic [$clog2(`BE_PHYS_REGS)-1:0] PhysIdx;
    typedef logic [$clog2(`BE_ROB_DEPTH)-1:0] RobIdx;

    // ------------------------------------------------------------------------
    // Bundles between pipeline blocks
    // ------------------------------------------------------------------------

    // As handed over by the front end
    typedef struct packed {
        AluOp       op;
        ArchIdx     rd;
        ArchIdx     rs1;
        ArchIdx     rs2;
        logic [7:0] imm;
    } FetchInst;

    typedef struct packed {
        AluOp       op;
        PhysIdx     prd;
        PhysIdx     prs1;
        PhysIdx     prs2;
        PhysIdx     oldPrd;
        ArchIdx     rd;
        logic [7:0] imm;
        RobIdx      robIdx;
    } RenamedInst;

    typedef struct packed {
        logic                valid;
        PhysIdx              prd;
        RobIdx               robIdx;
        logic [`BE_XLEN-1:0] result;
    } WbBundle;

    // oldPrd goes back to the free list on retire
    typedef struct packed {
        ArchIdx              rd;
        logic [`BE_XLEN-1:0] result;
        PhysIdx              oldPrd;
    } CommitBundle;

endpackage

`default_nettype wire

// File: source/Rename.sv
`timescale 1ns/10ps
`default_nettype none
`include "backend_defs.svh"

module Rename (
    input  logic                   clk,
    input  logic                   arstN,
    input  BackendPkg::FetchInst   fetchInst,
    input  logic                   dispatchFire,
    input  BackendPkg::RobIdx      robTail,
    input  logic                   retireValid,
    input  BackendPkg::PhysIdx     retireOldPrd,
    output BackendPkg::RenamedInst renamed,
    output logic                   renameValid
);
    import BackendPkg::*;

    localparam int FreeDepth = `BE_PHYS_REGS - `BE_ARCH_REGS;
    localparam int FreePtrW  = $clog2(FreeDepth);

    PhysIdx              mapTable [`BE_ARCH_REGS];
    PhysIdx              freeList [FreeDepth];
    logic [FreePtrW-1:0] freeHead;
    logic [FreePtrW-1:0] freeTail;
    logic [FreePtrW:0]   freeCount;
    logic                needsReg;
    logic                popFree;
    logic                pushFree;

    function automatic logic [FreePtrW-1:0] nextPtr(input logic [FreePtrW-1:0] ptr);
        return (ptr == FreePtrW'(FreeDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign needsReg    = fetchInst.rd != '0;
    assign renameValid = !needsReg || (freeCount != '0);
    assign popFree     = dispatchFire && needsReg;
    // p0 stays bound to r0 and never enters the list
    assign pushFree    = retireValid && (retireOldPrd != '0);

    always_comb begin
        renamed.op     = fetchInst.op;
        renamed.rd     = fetchInst.rd;
        renamed.imm    = fetchInst.imm;
        renamed.prs1   = mapTable[fetchInst.rs1];
        renamed.prs2   = mapTable[fetchInst.rs2];
        renamed.oldPrd = mapTable[fetchInst.rd];
        renamed.prd    = needsReg ? freeList[freeHead] : mapTable[fetchInst.rd];
        renamed.robIdx = robTail;
    end

    // ------------------------------------------------------------------------
    // Speculative map table
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `BE_ARCH_REGS; i++) begin
                mapTable[i] <= PhysIdx'(i);
            end
        end else if (popFree) begin
            mapTable[fetchInst.rd] <= freeList[freeHead];
        end
    end

    // ------------------------------------------------------------------------
    // Free list
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < FreeDepth; i++) begin
                freeList[i] <= PhysIdx'(`BE_ARCH_REGS + i);
            end
            freeHead  <= '0;
            freeTail  <= '0;
            freeCount <= (FreePtrW+1)'(FreeDepth);
        end else begin
            if (popFree) begin
                freeHead <= nextPtr(freeHead);
            end
            if (pushFree) begin
                freeList[freeTail] <= retireOldPrd;
                freeTail           <= nextPtr(freeTail);
            end
            case ({pushFree, popFree})
                2'b10:   freeCount <= freeCount + 1'b1;
                2'b01:   freeCount <= freeCount - 1'b1;
                default: freeCount <= freeCount;
            endcase
        end
    end

    // Dispatch must have waited for a free register
    assert property (@(posedge clk) disable iff (!arstN)
        popFree |-> (freeCount != '0))
        else $error("Rename: free list popped while empty");

endmodule

`default_nettype wire

// File: source/IntIssueQueue.sv
`timescale 1ns/10ps
`default_nettype none
`include "backend_defs.svh"

module IntIssueQueue (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   dispatchFire,
    input  BackendPkg::RenamedInst renamed,
    input  BackendPkg::WbBundle    wb,
    output logic                   full,
    output logic                   issueValid,
    output BackendPkg::RenamedInst issueInst
);
    import BackendPkg::*;

    localparam int Depth = `BE_IQ_DEPTH;
    localparam int SelW  = $clog2(Depth);

    typedef struct packed {
        logic       valid;
        logic       src1Ready;
        logic       src2Ready;
        RenamedInst inst;
    } IqEntry;

    // Index 0 holds the oldest entry
    IqEntry                   entries     [Depth];
    IqEntry                   nextEntries [Depth];
    logic [`BE_PHYS_REGS-1:0] busy;
    logic [Depth-1:0]         canIssue;
    logic [SelW-1:0]          issueSel;

    function automatic logic wakes(input PhysIdx src, input WbBundle w);
        return w.valid && (w.prd == src);
    endfunction

    // ------------------------------------------------------------------------
    // Select oldest ready
    // ------------------------------------------------------------------------

    always_comb begin
        issueSel = '0;
        for (int i = 0; i < Depth; i++) begin
            canIssue[i] = entries[i].valid && entries[i].src1Ready && entries[i].src2Ready;
        end
        for (int i = Depth - 1; i >= 0; i--) begin
            if (canIssue[i]) issueSel = SelW'(i);
        end
    end

    assign issueValid = |canIssue;
    assign issueInst  = entries[issueSel].inst;
    assign full       = entries[Depth-1].valid;

    // ------------------------------------------------------------------------
    // Wakeup, collapse and allocate
    // ------------------------------------------------------------------------

    always_comb begin
        logic placed;
        nextEntries = entries;
        for (int i = 0; i < Depth; i++) begin
            if (wakes(entries[i].inst.prs1, wb)) nextEntries[i].src1Ready = 1'b1;
            if (wakes(entries[i].inst.prs2, wb)) nextEntries[i].src2Ready = 1'b1;
        end
        // Entries above the issued one slide down to keep age order
        for (int i = 0; i < Depth - 1; i++) begin
            if (issueValid && (i >= int'(issueSel))) nextEntries[i] = nextEntries[i+1];
        end
        if (issueValid) nextEntries[Depth-1].valid = 1'b0;
        placed = 1'b0;
        for (int i = 0; i < Depth; i++) begin
            if (dispatchFire && !placed && !nextEntries[i].valid) begin
                nextEntries[i].valid     = 1'b1;
                nextEntries[i].inst      = renamed;
                nextEntries[i].src1Ready = !busy[renamed.prs1] || wakes(renamed.prs1, wb);
                nextEntries[i].src2Ready = !busy[renamed.prs2] || wakes(renamed.prs2, wb);
                placed                   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Depth; i++) begin
                entries[i] <= '0;
            end
        end else begin
            entries <= nextEntries;
        end
    end

    // One busy bit per physical register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= '0;
        end else begin
            if (wb.valid) busy[wb.prd] <= 1'b0;
            if (dispatchFire && (renamed.prd != '0)) busy[renamed.prd] <= 1'b1;
        end
    end

    // Per-entry ready flags must agree with the busy table
    assert property (@(posedge clk) disable iff (!arstN)
        issueValid |-> !busy[issueInst.prs1] && !busy[issueInst.prs2])
        else $error("IntIssueQueue: issued with a busy source");

endmodule

`default_nettype wire

// File: source/Execute.sv
`timescale 1ns/10ps
`default_nettype none
`include "backend_defs.svh"

module Execute (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   issueValid,
    input  BackendPkg::RenamedInst issueInst,
    output BackendPkg::WbBundle    wb
);
    import BackendPkg::*;

    logic [`BE_XLEN-1:0] regFile [`BE_PHYS_REGS];
    logic [`BE_XLEN-1:0] src1;
    logic [`BE_XLEN-1:0] src2;
    logic [`BE_XLEN-1:0] immExt;
    logic [`BE_XLEN-1:0] aluOut;
    logic                wbValid;
    PhysIdx              wbPrd;
    RobIdx               wbRobIdx;
    logic [`BE_XLEN-1:0] wbResult;

    // ------------------------------------------------------------------------
    // Register read and ALU
    // ------------------------------------------------------------------------

    assign src1   = (issueInst.prs1 == '0) ? '0 : regFile[issueInst.prs1];
    assign src2   = (issueInst.prs2 == '0) ? '0 : regFile[issueInst.prs2];
    assign immExt = {{(`BE_XLEN-8){issueInst.imm[7]}}, issueInst.imm};

    always_comb begin
        case (issueInst.op)
            AluAdd:  aluOut = src1 + src2;
            AluSub:  aluOut = src1 - src2;
            AluAnd:  aluOut = src1 & src2;
            AluOr:   aluOut = src1 | src2;
            AluXor:  aluOut = src1 ^ src2;
            AluAddi: aluOut = src1 + immExt;
            default: aluOut = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Writeback stage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= issueValid;
        end
    end

    // rd 0 results are architecturally zero
    always_ff @(posedge clk) begin
        wbPrd    <= issueInst.prd;
        wbRobIdx <= issueInst.robIdx;
        wbResult <= (issueInst.prd == '0) ? '0 : aluOut;
    end

    always_ff @(posedge clk) begin
        if (wbValid && (wbPrd != '0)) begin
            regFile[wbPrd] <= wbResult;
        end
    end

    assign wb = '{valid: wbValid, prd: wbPrd, robIdx: wbRobIdx, result: wbResult};

endmodule

`default_nettype wire

// File: source/Rob.sv
`timescale 1ns/10ps
`default_nettype none
`include "backend_defs.svh"

module Rob (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    dispatchFire,
    input  BackendPkg::RenamedInst  renamed,
    input  BackendPkg::WbBundle     wb,
    output BackendPkg::RobIdx       robTail,
    output logic                    full,
    output logic                    commitValid,
    output BackendPkg::CommitBundle commit,
    input  logic                    commitReady,
    output logic                    retireValid
);
    import BackendPkg::*;

    localparam int Depth = `BE_ROB_DEPTH;

    logic [Depth-1:0]       done;
    ArchIdx                 entryRd     [Depth];
    PhysIdx                 entryOldPrd [Depth];
    logic [`BE_XLEN-1:0]    entryResult [Depth];
    RobIdx                  head;
    RobIdx                  tail;
    logic [$clog2(Depth):0] count;
    int                     wbOffset;

    function automatic RobIdx nextIdx(input RobIdx idx);
        return (idx == RobIdx'(Depth - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign robTail     = tail;
    assign full        = count == ($clog2(Depth)+1)'(Depth);
    assign commitValid = (count != '0) && done[head];
    assign retireValid = commitValid && commitReady;
    assign commit      = '{rd: entryRd[head], result: entryResult[head],
                           oldPrd: entryOldPrd[head]};

    // ------------------------------------------------------------------------
    // Pointers and status
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (dispatchFire) begin
                done[tail] <= 1'b0;
                tail       <= nextIdx(tail);
            end
            if (wb.valid) done[wb.robIdx] <= 1'b1;
            if (retireValid) head <= nextIdx(head);
            case ({dispatchFire, retireValid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (dispatchFire) begin
            entryRd[tail]     <= renamed.rd;
            entryOldPrd[tail] <= renamed.oldPrd;
        end
        if (wb.valid) entryResult[wb.robIdx] <= wb.result;
    end

    // Distance of the writeback slot from the head
    always_comb begin
        if (wb.robIdx >= head) wbOffset = int'(wb.robIdx) - int'(head);
        else wbOffset = int'(wb.robIdx) + Depth - int'(head);
    end

    assert property (@(posedge clk) disable iff (!arstN)
        wb.valid |-> (wbOffset < int'(count)))
        else $error("Rob: writeback to an entry that is not allocated");

endmodule

`default_nettype wire

// File: source/Backend.sv
`timescale 1ns/10ps
`default_nettype none
`include "backend_defs.svh"

module Backend (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 fetchValid,
    input  BackendPkg::FetchInst fetchInst,
    output logic                 fetchReady,
    output logic                 commitValid,
    output BackendPkg::ArchIdx   commitRd,
    output logic [`BE_XLEN-1:0]  commitResult,
    input  logic                 commitReady
);
    import BackendPkg::*;

    RenamedInst  renamed;
    RenamedInst  issueInst;
    WbBundle     wb;
    CommitBundle commitBundle;
    RobIdx       robTail;
    logic        renameValid;
    logic        dispatchFire;
    logic        robFull;
    logic        iqFull;
    logic        issueValid;
    logic        retireValid;

    // ------------------------------------------------------------------------
    // Dispatch control
    // ------------------------------------------------------------------------

    // One instruction enters rename, ROB and issue queue together
    assign dispatchFire = fetchValid && renameValid && !robFull && !iqFull;
    assign fetchReady   = dispatchFire;

    assign commitRd     = commitBundle.rd;
    assign commitResult = commitBundle.result;

    Rename rename (.*,
                   .retireOldPrd(commitBundle.oldPrd));

    IntIssueQueue intIssueQueue (.*,
                                 .full(iqFull));

    Execute execute (.*);

    Rob rob (.*,
             .full(robFull),
             .commit(commitBundle));

endmodule

`default_nettype wire

// File: bench/BackendTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "backend_defs.svh"

module BackendTb;
    import BackendPkg::*;

    localparam int ClkPeriod  = 8;
    localparam int TotalInsts = 400;
    localparam int StallAt    = 200;
    localparam int StallLen   = 30;
    localparam int WatchdogNs = TotalInsts * 40 * ClkPeriod;

    typedef struct packed {
        ArchIdx              rd;
        logic [`BE_XLEN-1:0] result;
    } ExpCommit;

    logic                clk;
    logic                arstN;
    logic                fetchValid;
    FetchInst            fetchInst;
    logic                fetchReady;
    logic                commitValid;
    ArchIdx              commitRd;
    logic [`BE_XLEN-1:0] commitResult;
    logic                commitReady;

    logic [31:0]         lcgState = 32'h5911_d892;
    logic [`BE_XLEN-1:0] archRegs [`BE_ARCH_REGS];
    ExpCommit            expected [$];
    ArchIdx              lastRd;
    int                  errors;
    int                  sent;
    int                  committed;
    int                  stallLeft;
    int                  stallFetches;
    logic                stallPhase;
    logic                stallDone;
    logic                xfer;
    logic                prevWaiting;
    ArchIdx              heldRd;
    logic [`BE_XLEN-1:0] heldResult;

    Backend i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    function automatic int randBelow(input int n);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return int'(lcgState[31:8]) % n;
    endfunction

    // Sources lean on the last written register to build dependency chains
    function automatic FetchInst randomInst();
        FetchInst inst;
        inst.op  = AluOp'(3'(randBelow(6)));
        inst.rd  = ArchIdx'(randBelow(`BE_ARCH_REGS));
        inst.rs1 = (randBelow(2) == 0) ? lastRd : ArchIdx'(randBelow(`BE_ARCH_REGS));
        inst.rs2 = (randBelow(2) == 0) ? lastRd : ArchIdx'(randBelow(`BE_ARCH_REGS));
        inst.imm = 8'(randBelow(256));
        return inst;
    endfunction

    task automatic driveInputs();
        if (!stallDone && sent >= StallAt) begin
            stallLeft  = StallLen;
            stallPhase = 1'b1;
            stallDone  = 1'b1;
        end
        if (stallLeft > 0) begin
            commitReady = 1'b0;
            stallLeft--;
        end else begin
            commitReady = randBelow(10) < 7;
        end
        if (xfer) fetchValid = 1'b0;
        if (!fetchValid && sent < TotalInsts) begin
            if (stallPhase || randBelow(8) != 0) begin
                fetchInst  = randomInst();
                fetchValid = 1'b1;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Architectural model and checks
    // ------------------------------------------------------------------------

    task automatic executeModel(input FetchInst inst);
        logic [`BE_XLEN-1:0] a;
        logic [`BE_XLEN-1:0] b;
        logic [`BE_XLEN-1:0] res;
        a = archRegs[inst.rs1];
        b = archRegs[inst.rs2];
        case (inst.op)
            AluAdd:  res = a + b;
            AluSub:  res = a - b;
            AluAnd:  res = a & b;
            AluOr:   res = a | b;
            AluXor:  res = a ^ b;
            AluAddi: res = a + {{(`BE_XLEN-8){inst.imm[7]}}, inst.imm};
            default: res = '0;
        endcase
        if (inst.rd == '0) res = '0;
        else archRegs[inst.rd] = res;
        if (inst.rd != '0) lastRd = inst.rd;
        expected.push_back('{rd: inst.rd, result: res});
    endtask

    task automatic checkCommit();
        ExpCommit exp;
        assert (expected.size() > 0) else begin
            errors++;
            $display("A commit arrived at %0t with no instruction outstanding", $time);
        end
        if (expected.size() > 0) begin
            exp = expected.pop_front();
            assert (commitRd == exp.rd && commitResult == exp.result) else begin
                errors++;
                $display("** Error [%0t] commit %0d: rd %0d result %h, expected rd %0d result %h",
                         $time, committed, commitRd, commitResult, exp.rd, exp.result);
            end
        end
        committed++;
    endtask

    task automatic sampleCycle();
        xfer = fetchValid && fetchReady;
        if (sent == 0) begin
            assert (!commitValid) else begin
                errors++;
                $display("** Error [%0t] commitValid high before any fetch transfer", $time);
            end
        end
        if (prevWaiting) begin
            assert (commitValid && commitRd == heldRd && commitResult == heldResult) else begin
                errors++;
                $display("** Error [%0t] commit payload changed while waiting", $time);
            end
        end
        if (xfer) begin
            executeModel(fetchInst);
            sent++;
            if (stallPhase) stallFetches++;
        end
        if (commitValid && commitReady) checkCommit();
        prevWaiting = commitValid && !commitReady;
        heldRd      = commitRd;
        heldResult  = commitResult;
        // Last cycle of the held-off commit stretch
        if (stallPhase && stallLeft == 0) begin
            assert (!fetchReady && stallFetches <= `BE_ROB_DEPTH) else begin
                errors++;
                $display("** Error [%0t] stall: fetchReady %b after %0d fetches",
                         $time, fetchReady, stallFetches);
            end
            stallPhase = 1'b0;
        end
    endtask

    initial begin
        #(WatchdogNs);
        $display("Timeout: only %0d of %0d instructions committed", committed, TotalInsts);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        arstN        = 1'b0;
        fetchValid   = 1'b0;
        fetchInst    = '0;
        commitReady  = 1'b0;
        lastRd       = '0;
        errors       = 0;
        sent         = 0;
        committed    = 0;
        stallLeft    = 0;
        stallFetches = 0;
        stallPhase   = 1'b0;
        stallDone    = 1'b0;
        xfer         = 1'b0;
        prevWaiting  = 1'b0;
        heldRd       = '0;
        heldResult   = '0;
        for (int i = 0; i < `BE_ARCH_REGS; i++) archRegs[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;
        assert (!commitValid) else begin
            errors++;
            $display("** Error [%0t] commitValid high after reset", $time);
        end
        while (!(sent == TotalInsts && committed == TotalInsts)) begin
            driveInputs();
            @(negedge clk);
            sampleCycle();
            @(posedge clk);
            #1;
        end
        fetchValid = 1'b0;
        repeat (20) begin
            @(negedge clk);
            assert (!commitValid) else begin
                errors++;
                $display("An extra commit appeared at %0t after the last instruction", $time);
            end
        end
        assert (expected.size() == 0 && committed == sent) else begin
            errors++;
            $display("%0d expected commits left over, %0d committed of %0d fetched",
                     expected.size(), committed, sent);
        end
        $display("Summary: %0d errors, %0d fetched, %0d committed", errors, sent, committed);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/BackendPkg.sv
source/Rename.sv
source/IntIssueQueue.sv
source/Execute.sv
source/Rob.sv
source/Backend.sv
bench/BackendTb.sv

// File: run.sh
#!/bin/sh
# Build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module BackendTb -o BackendTb

status=0
./obj_dir/BackendTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
